// File: project.f
+incdir+src
src/la_reg_pkg.sv
src/la_capture_pkg.sv
src/la_config_if.sv
src/la_register_file.sv
src/la_trigger_select.sv
src/la_channel_select.sv
src/la_capture_ctrl.sv
src/la_sample_packer.sv
src/la_top.sv
bench/tb_la_top.sv

// File: Bender.yml
package:
  name: la_capture

sources:
  - include_dirs:
      - src
    files:
      - src/la_reg_pkg.sv
      - src/la_capture_pkg.sv
      - src/la_config_if.sv
      - src/la_register_file.sv
      - src/la_trigger_select.sv
      - src/la_channel_select.sv
      - src/la_capture_ctrl.sv
      - src/la_sample_packer.sv
      - src/la_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/tb_la_top.sv

// File: bench/tb_la_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "la_defines.svh"

module tb_la_top;

   // Longest capture is 32 samples at 8 cycles each, plus launch latency
   localparam int CAPTURE_CYCLES = 32 * 8 + 40;
   localparam int TIMEOUT_CYCLES = 16 + 5 * CAPTURE_CYCLES + 600;  // Reset, captures, registers

   logic                       observer_clk = 1'b0;
   logic                       reset;
   la_reg_pkg::reg_addr_t      reg_address;
   la_reg_pkg::byte_sel_t      reg_bytecnt;
   la_reg_pkg::reg_data_t      reg_datai;
   la_reg_pkg::reg_data_t      reg_datao;
   logic                       reg_read;
   logic                       reg_write;
   logic                       ext_trigger;
   logic [3:0]                 io_pins;
   logic [7:0]                 user_io;
   logic                       user_io_clk;
   la_capture_pkg::sample_t    probe_pins;
   la_capture_pkg::sample_t    debug_bus;
   logic                       capture_start;
   logic                       capture_done;
   logic                       fifo_wr;
   la_capture_pkg::fifo_word_t fifo_wr_data;

   int unsigned                lcg_state = 46282;
   int                         cycle_count = 0;
   int                         start_count = 0;
   int                         done_count = 0;
   int                         start_cycle;
   int                         done_cycle;
   la_capture_pkg::fifo_word_t words[$];
   int                         word_cycles[$];

   la_top la_top_i (.*);

   always #10 observer_clk = ~observer_clk;

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   always @(posedge observer_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
         report_failure("Timeout: the tests did not finish within the cycle limit");
   end

   // Monitor sees outputs as they were before the edge
   always @(posedge observer_clk) begin
      if (fifo_wr) begin
         words.push_back(fifo_wr_data);
         word_cycles.push_back(cycle_count);
      end
      if (capture_start) begin
         start_count++;
         start_cycle = cycle_count;
      end
      if (capture_done) begin
         done_count++;
         done_cycle = cycle_count;
      end
   end

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;  // Upper bits only
   endfunction

   task automatic expect_equal(input int actual, input int expected, input string what);
      assert (actual == expected) else
         report_failure($sformatf("Fail at %0t ns: %s is %0d, expected %0d",
                                  $time, what, actual, expected));
   endtask

   task automatic reg_wr(input int addr, input int bytecnt, input int data);
      @(posedge observer_clk);
      reg_address <= addr;
      reg_bytecnt <= bytecnt;
      reg_datai   <= data;
      reg_write   <= 1'b1;
      @(posedge observer_clk);
      reg_write   <= 1'b0;
   endtask

   // Read data is combinational, taken at the edge after the address
   task automatic reg_rd(input int addr, input int bytecnt, input bit strobe, output int data);
      @(posedge observer_clk);
      reg_address <= addr;
      reg_bytecnt <= bytecnt;
      reg_read    <= strobe;
      @(posedge observer_clk);
      data = reg_datao;
      reg_read    <= 1'b0;
   endtask

   task automatic expect_reg(input int addr, input int bytecnt, input int expected,
                             input string what);
      int data;
      reg_rd(addr, bytecnt, 1'b1, data);
      expect_equal(data, expected, what);
   endtask

   task automatic setup_capture(input int group, input int depth, input int downsample);
      reg_wr(`LA_ADDR_CAPTURE_GROUP, 0, group);
      for (int i = 0; i < 4; i++)
         reg_wr(`LA_ADDR_CAPTURE_DEPTH, i, depth >> (8 * i));
      for (int i = 0; i < 2; i++)
         reg_wr(`LA_ADDR_DOWNSAMPLE, i, downsample >> (8 * i));
      words.delete();
      word_cycles.delete();
      start_count = 0;
      done_count  = 0;
   endtask

   task automatic wait_done();
      int waited;
      waited = 0;
      do begin
         @(posedge observer_clk);
         waited++;
      end while (!capture_done && waited < CAPTURE_CYCLES);
      assert (capture_done) else report_failure("Capture never signalled capture_done");
      repeat (2) @(posedge observer_clk);  // Let the monitor count it
   endtask

   task automatic check_framing(input int n);
      expect_equal(words.size(), n, "FIFO write count");
      expect_equal(start_count, 1, "capture_start pulses");
      expect_equal(done_count, 1, "capture_done pulses");
      expect_equal(start_cycle < word_cycles[0], 1, "capture_start before first write");
      expect_equal(done_cycle > word_cycles[$], 1, "capture_done after last write");
   endtask

   task automatic test_register_readback();
      int trig;
      int group;
      int depth;
      int ds;
      int data;
      trig  = lcg_next() & 'h3F;
      group = lcg_next() & 'h7;
      depth = (lcg_next() << 16) | lcg_next();
      ds    = lcg_next() & 'hFFFF;
      reg_wr(`LA_ADDR_TRIGGER_SOURCE, 0, trig);
      reg_wr(`LA_ADDR_CAPTURE_GROUP, 0, group);
      for (int i = 0; i < 4; i++)
         reg_wr(`LA_ADDR_CAPTURE_DEPTH, i, depth >> (8 * i));
      for (int i = 0; i < 2; i++)
         reg_wr(`LA_ADDR_DOWNSAMPLE, i, ds >> (8 * i));
      expect_reg(`LA_ADDR_TRIGGER_SOURCE, 0, trig, "trigger source readback");
      expect_reg(`LA_ADDR_CAPTURE_GROUP, 0, group, "capture group readback");
      for (int i = 0; i < 4; i++)
         expect_reg(`LA_ADDR_CAPTURE_DEPTH, i, (depth >> (8 * i)) & 'hFF, "depth byte");
      for (int i = 0; i < 2; i++)
         expect_reg(`LA_ADDR_DOWNSAMPLE, i, (ds >> (8 * i)) & 'hFF, "downsample byte");
      reg_rd(`LA_ADDR_CAPTURE_DEPTH, 0, 1'b0, data);  // No read strobe
      expect_equal(data, 0, "read data without reg_read");
   endtask

   // Ramp advances once per cycle, so pairs differ by the sample period
   task automatic test_ramp_capture(input int downsample);
      int n;
      n = lcg_next() % 16 + 1;
      reg_wr(`LA_ADDR_TRIGGER_SOURCE, 0, 0);
      setup_capture(`LA_GROUP_RAMP, 2 * n, downsample);
      reg_wr(`LA_ADDR_ARM, 0, 1);
      reg_wr(`LA_ADDR_MANUAL_CAPTURE, 0, 1);
      wait_done();
      reg_wr(`LA_ADDR_MANUAL_CAPTURE, 0, 0);
      check_framing(n);
      foreach (words[i])
         expect_equal((words[i][8:0] - words[i][17:9]) & 9'h1FF, downsample + 1,
                      "ramp pair step");
      expect_reg(`LA_ADDR_STATUS, 0, 0, "status after capture");
   endtask

   task automatic test_arm_trigger();
      reg_wr(`LA_ADDR_TRIGGER_SOURCE, 0, 0);
      setup_capture(`LA_GROUP_RAMP, 4, 0);
      @(posedge observer_clk) ext_trigger <= 1'b1;
      repeat (4) @(posedge observer_clk);
      ext_trigger <= 1'b0;
      repeat (10) @(posedge observer_clk);
      expect_equal(start_count, 0, "capture_start while disarmed");
      expect_equal(words.size(), 0, "FIFO writes while disarmed");
      reg_wr(`LA_ADDR_ARM, 0, 1);
      @(posedge observer_clk) ext_trigger <= 1'b1;
      wait_done();
      reg_wr(`LA_ADDR_ARM, 0, 1);  // Rearmed with the trigger still high
      repeat (30) @(posedge observer_clk);
      check_framing(2);
      ext_trigger <= 1'b0;
      reg_wr(`LA_ADDR_ARM, 0, 0);
   endtask

   task automatic test_pin_trigger();
      int n;
      la_capture_pkg::sample_t probe;
      n     = lcg_next() % 16 + 1;
      probe = lcg_next();
      @(posedge observer_clk);
      probe_pins <= probe;
      io_pins    <= 4'b0000;
      reg_wr(`LA_ADDR_TRIGGER_SOURCE, 0, 6'b101010);  // io pin 2 inverted
      setup_capture(`LA_GROUP_PINS, 2 * n, lcg_next() % 8);
      reg_wr(`LA_ADDR_ARM, 0, 1);
      @(posedge observer_clk) io_pins <= 4'b0100;  // Wrong sense
      repeat (6) @(posedge observer_clk);
      io_pins <= 4'b1111;
      repeat (6) @(posedge observer_clk);
      expect_equal(start_count, 0, "capture on wrong io pin or sense");
      io_pins <= 4'b1011;
      wait_done();
      check_framing(n);
      foreach (words[i]) begin
         expect_equal(words[i][17:9], probe, "older pin sample");
         expect_equal(words[i][8:0], probe, "newer pin sample");
      end
   endtask

   task automatic test_user_trigger();
      int n;
      n = lcg_next() % 16 + 1;
      @(posedge observer_clk) user_io <= 8'h00;
      reg_wr(`LA_ADDR_TRIGGER_SOURCE, 0, 6'b001101);  // user_io pin 5
      setup_capture(6, 2 * n, 0);
      reg_wr(`LA_ADDR_ARM, 0, 1);
      @(posedge observer_clk) user_io <= 8'hDF;
      repeat (6) @(posedge observer_clk);
      expect_equal(start_count, 0, "capture on other user_io pins");
      user_io <= 8'hFF;
      wait_done();
      check_framing(n);
      foreach (words[i])
         expect_equal(words[i], {`LA_ALT_PATTERN, `LA_ALT_PATTERN}, "fixed pattern word");
   endtask

   initial begin
      reset       = 1'b1;
      reg_address = '0;
      reg_bytecnt = '0;
      reg_datai   = '0;
      reg_read    = 1'b0;
      reg_write   = 1'b0;
      ext_trigger = 1'b0;
      io_pins     = '0;
      user_io     = '0;
      user_io_clk = 1'b0;
      probe_pins  = '0;
      debug_bus   = 9'h0A5;
      repeat (16) @(posedge observer_clk);
      reset <= 1'b0;
      test_register_readback();
      test_ramp_capture(0);
      test_ramp_capture(lcg_next() % 8);
      test_arm_trigger();
      test_pin_trigger();
      test_user_trigger();
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: src/la_top.sv
`timescale 1ns/1ns
`default_nettype none

module la_top (
   input  wire                          observer_clk,
   input  wire                          reset,
   input  wire la_reg_pkg::reg_addr_t   reg_address,
   input  wire la_reg_pkg::byte_sel_t   reg_bytecnt,
   input  wire la_reg_pkg::reg_data_t   reg_datai,
   input  wire                          reg_read,
   input  wire                          reg_write,
   input  wire                          ext_trigger,
   input  wire  [3:0]                   io_pins,
   input  wire  [7:0]                   user_io,
   input  wire                          user_io_clk,
   input  wire la_capture_pkg::sample_t probe_pins,
   input  wire la_capture_pkg::sample_t debug_bus,
   output la_reg_pkg::reg_data_t        reg_datao,
   output logic                         capture_start,
   output logic                         capture_done,
   output logic                         fifo_wr,
   output la_capture_pkg::fifo_word_t   fifo_wr_data
);

   logic                    trigger_edge;
   logic                    sample_strobe;
   la_capture_pkg::sample_t sample;

   la_config_if cfg_if ();

   la_register_file la_register_file_i (.observer_clk, .reset, .reg_address, .reg_bytecnt,
      .reg_datai, .reg_read, .reg_write, .reg_datao, .cfg(cfg_if.regs));

   la_trigger_select la_trigger_select_i (.observer_clk, .reset, .ext_trigger, .io_pins,
      .user_io, .cfg(cfg_if.trigger), .trigger_edge);

   la_channel_select la_channel_select_i (.observer_clk, .reset, .probe_pins, .user_io,
      .user_io_clk, .debug_bus, .cfg(cfg_if.channel), .sample);

   la_capture_ctrl la_capture_ctrl_i (.observer_clk, .reset, .trigger_edge,
      .cfg(cfg_if.ctrl), .sample_strobe, .capture_start, .capture_done);

   // Packer restarts its pairing with each capture
   la_sample_packer la_sample_packer_i (.observer_clk, .reset,
      .capture_go(cfg_if.capture_go), .sample_strobe, .sample, .fifo_wr, .fifo_wr_data);

endmodule

`default_nettype wire

// File: src/la_sample_packer.sv
`timescale 1ns/1ns
`default_nettype none

module la_sample_packer (
   input  wire                          observer_clk,
   input  wire                          reset,
   input  wire                          capture_go,
   input  wire                          sample_strobe,
   input  wire la_capture_pkg::sample_t sample,
   output logic                         fifo_wr,
   output la_capture_pkg::fifo_word_t   fifo_wr_data
);

   la_capture_pkg::sample_t older;
   la_capture_pkg::sample_t newer;
   logic                    pair_toggle;  // High after first sample of a pair

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         pair_toggle <= 1'b0;
         fifo_wr     <= 1'b0;
      end else begin
         fifo_wr <= 1'b0;
         if (capture_go) begin
            pair_toggle <= 1'b0;
         end else if (sample_strobe) begin
            pair_toggle <= ~pair_toggle;
            fifo_wr     <= pair_toggle;
         end
      end
   end

   // Two-deep shift per channel
   always_ff @(posedge observer_clk) begin
      if (sample_strobe) begin
         older <= newer;
         newer <= sample;
      end
   end

   assign fifo_wr_data = {older, newer};

   // Pairing relies on a launch never coinciding with a strobe
   a_go_strobe_apart: assert property (@(posedge observer_clk) disable iff (reset)
      !(capture_go && sample_strobe));

endmodule

`default_nettype wire

// File: src/la_capture_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module la_capture_ctrl (
   input  wire       observer_clk,
   input  wire       reset,
   input  wire       trigger_edge,
   la_config_if.ctrl cfg,
   output logic      sample_strobe,
   output logic      capture_start,
   output logic      capture_done
);

   la_capture_pkg::capture_state_t state;
   la_capture_pkg::depth_t         sample_count;
   la_capture_pkg::downsample_t    div_count;
   logic                           capturing_q;

   // Launch only when armed and not already running
   assign cfg.capture_go = trigger_edge & cfg.arm & (state == la_capture_pkg::CAP_IDLE);
   assign cfg.capturing  = (state == la_capture_pkg::CAP_RUN);
   assign sample_strobe  = cfg.capturing & (div_count == cfg.downsample);

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         state        <= la_capture_pkg::CAP_IDLE;
         sample_count <= '0;
         div_count    <= '0;
      end else if (cfg.capture_go) begin
         state        <= la_capture_pkg::CAP_RUN;
         sample_count <= '0;
         div_count    <= '0;  // Divider phase locked to the trigger
      end else if (cfg.capturing) begin
         if (sample_strobe) begin
            div_count    <= '0;
            sample_count <= sample_count + 1'b1;
            if (sample_count == cfg.depth - 1'b1)
               state <= la_capture_pkg::CAP_IDLE;  // Last sample taken
         end else begin
            div_count <= div_count + 1'b1;
         end
      end
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         capturing_q   <= 1'b0;
         capture_start <= 1'b0;
         capture_done  <= 1'b0;
      end else begin
         capturing_q   <= cfg.capturing;
         capture_start <= cfg.capturing & ~capturing_q;
         capture_done  <= ~cfg.capturing & capturing_q;
      end
   end

   // Strobes never run past the programmed depth
   a_within_depth: assert property (@(posedge observer_clk) disable iff (reset)
      sample_strobe |-> sample_count < cfg.depth);

endmodule

`default_nettype wire

// File: src/la_channel_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "la_defines.svh"

module la_channel_select (
   input  wire                          observer_clk,
   input  wire                          reset,
   input  wire la_capture_pkg::sample_t probe_pins,
   input  wire  [7:0]                   user_io,
   input  wire                          user_io_clk,
   input  wire la_capture_pkg::sample_t debug_bus,
   la_config_if.channel                 cfg,
   output la_capture_pkg::sample_t      sample
);

   la_capture_pkg::sample_t ramp;

   // Free-running test pattern
   always_ff @(posedge observer_clk) begin
      if (reset)
         ramp <= '0;
      else
         ramp <= ramp + 1'b1;
   end

   always_ff @(posedge observer_clk) begin
      case (cfg.group_sel)
         `LA_GROUP_PINS:   sample <= probe_pins;
         `LA_GROUP_USERIO: sample <= {user_io_clk, user_io};  // Clock on top
         `LA_GROUP_DEBUG:  sample <= debug_bus;
         `LA_GROUP_RAMP:   sample <= ramp;
         default:          sample <= `LA_ALT_PATTERN;
      endcase
   end

endmodule

`default_nettype wire

// File: src/la_trigger_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "la_defines.svh"

module la_trigger_select (
   input  wire        observer_clk,
   input  wire        reset,
   input  wire        ext_trigger,
   input  wire  [3:0] io_pins,
   input  wire  [7:0] user_io,
   la_config_if.trigger cfg,
   output logic       trigger_edge
);

   logic trig_src;
   logic trig_r1;
   logic trig_r2;

   always_comb begin
      trig_src = 1'b0;
      if (cfg.trigger_sel == '0)
         trig_src = ext_trigger;
      else if (cfg.trigger_sel[`LA_TRIG_PIN_BIT])
         trig_src = io_pins[cfg.trigger_sel[1:0]] ^ cfg.trigger_sel[`LA_TRIG_PIN_INV_BIT];
      else if (cfg.trigger_sel[`LA_TRIG_USER_BIT])
         trig_src = user_io[cfg.trigger_sel[2:0]] ^ cfg.trigger_sel[`LA_TRIG_USER_INV_BIT];
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trig_r1      <= 1'b0;
         trig_r2      <= 1'b0;
         trigger_edge <= 1'b0;
      end else begin
         trig_r1      <= trig_src | cfg.manual;  // Manual forces a level
         trig_r2      <= trig_r1;
         trigger_edge <= trig_r1 & ~trig_r2;      // Rising edge only
      end
   end

endmodule

`default_nettype wire

// File: src/la_register_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "la_defines.svh"

module la_register_file (
   input  wire                        observer_clk,
   input  wire                        reset,
   input  wire la_reg_pkg::reg_addr_t reg_address,
   input  wire la_reg_pkg::byte_sel_t reg_bytecnt,
   input  wire la_reg_pkg::reg_data_t reg_datai,
   input  wire                        reg_read,
   input  wire                        reg_write,
   output la_reg_pkg::reg_data_t      reg_datao,
   la_config_if.regs                  cfg
);

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         cfg.trigger_sel <= '0;  // ext_trigger
         cfg.group_sel   <= '0;
         cfg.depth       <= '0;
         cfg.downsample  <= '0;
         cfg.manual      <= 1'b0;
      end else if (reg_write) begin
         case (reg_address)
            `LA_ADDR_TRIGGER_SOURCE: cfg.trigger_sel <= reg_datai[5:0];
            `LA_ADDR_CAPTURE_GROUP:  cfg.group_sel <= reg_datai[2:0];
            `LA_ADDR_CAPTURE_DEPTH:  cfg.depth[reg_bytecnt*8 +: 8] <= reg_datai;
            `LA_ADDR_MANUAL_CAPTURE: cfg.manual <= reg_datai[0];
            `LA_ADDR_DOWNSAMPLE: begin
               if (!reg_bytecnt[1])  // Only two bytes wide
                  cfg.downsample[reg_bytecnt[0]*8 +: 8] <= reg_datai;
            end
            default: ;
         endcase
      end
   end

   // Arm drops as soon as a capture is launched
   always_ff @(posedge observer_clk) begin
      if (reset)
         cfg.arm <= 1'b0;
      else if (cfg.capture_go)
         cfg.arm <= 1'b0;
      else if (reg_write && reg_address == `LA_ADDR_ARM)
         cfg.arm <= reg_datai[0];
   end

   always_comb begin
      reg_datao = '0;
      if (reg_read) begin
         case (reg_address)
            `LA_ADDR_CAPTURE_GROUP:  reg_datao = {5'b0, cfg.group_sel};
            `LA_ADDR_STATUS:         reg_datao = {6'b0, cfg.arm, cfg.capturing};
            `LA_ADDR_TRIGGER_SOURCE: reg_datao = {2'b0, cfg.trigger_sel};
            `LA_ADDR_CAPTURE_DEPTH:  reg_datao = cfg.depth[reg_bytecnt*8 +: 8];
            `LA_ADDR_MANUAL_CAPTURE: reg_datao = {7'b0, cfg.manual};
            `LA_ADDR_ARM:            reg_datao = {7'b0, cfg.arm};
            `LA_ADDR_DOWNSAMPLE: begin
               if (!reg_bytecnt[1])
                  reg_datao = cfg.downsample[reg_bytecnt[0]*8 +: 8];
            end
            default: ;
         endcase
      end
   end

   // Arm falls on the same edge where capturing rises
   a_arm_cleared: assert property (@(posedge observer_clk) disable iff (reset)
      $rose(cfg.capturing) |-> $fell(cfg.arm));

endmodule

`default_nettype wire

// File: src/la_config_if.sv
`timescale 1ns/1ns
`default_nettype none

interface la_config_if;

   // Settings from the register file
   la_reg_pkg::trigger_sel_t    trigger_sel;
   la_reg_pkg::group_sel_t      group_sel;
   la_capture_pkg::depth_t      depth;
   la_capture_pkg::downsample_t downsample;
   logic                        manual;
   logic                        arm;

   // Capture status
   logic                        capture_go;
   logic                        capturing;

   modport regs (output trigger_sel, group_sel, depth, downsample, manual, arm,
                 input  capture_go, capturing);
   modport ctrl (input  depth, downsample, arm,
                 output capture_go, capturing);
   modport trigger (input trigger_sel, manual);
   modport channel (input group_sel);

endinterface

`default_nettype wire

// File: src/la_capture_pkg.sv
`default_nettype none

`include "la_defines.svh"

package la_capture_pkg;

   typedef logic [`LA_CHANNELS-1:0]   sample_t;
   typedef logic [2*`LA_CHANNELS-1:0] fifo_word_t;  // Older sample on top

   typedef logic [31:0] depth_t;       // Samples per capture
   typedef logic [15:0] downsample_t;  // Divider reload

   typedef enum logic {
      CAP_IDLE,
      CAP_RUN
   } capture_state_t;

endpackage

`default_nettype wire

// File: src/la_reg_pkg.sv
`default_nettype none

package la_reg_pkg;

   typedef logic [7:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;

   // Byte lane of depth and downsample
   typedef logic [1:0] byte_sel_t;

   typedef logic [5:0] trigger_sel_t;  // See LA_TRIG_* fields
   typedef logic [2:0] group_sel_t;

endpackage

`default_nettype wire

// File: src/la_defines.svh
`ifndef LA_DEFINES_SVH
`define LA_DEFINES_SVH

// Probe channels per sample
`define LA_CHANNELS 9

// Register map
`define LA_ADDR_CAPTURE_GROUP   8'd0
`define LA_ADDR_STATUS          8'd1
`define LA_ADDR_TRIGGER_SOURCE  8'd3
`define LA_ADDR_CAPTURE_DEPTH   8'd5
`define LA_ADDR_MANUAL_CAPTURE  8'd6
`define LA_ADDR_ARM             8'd7
`define LA_ADDR_DOWNSAMPLE      8'd8

// Capture group codes with 4 to 7 giving the fixed pattern
`define LA_GROUP_PINS    3'd0
`define LA_GROUP_USERIO  3'd1
`define LA_GROUP_DEBUG   3'd2
`define LA_GROUP_RAMP    3'd3

`define LA_TRIG_PIN_BIT       5  // io pin select
`define LA_TRIG_PIN_INV_BIT   3
`define LA_TRIG_USER_BIT      3  // user_io select when pin bit is clear
`define LA_TRIG_USER_INV_BIT  4

`define LA_ALT_PATTERN 9'b1_0101_0101
`endif
